// ==== files.f ====
core_pkg.sv
regfile.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
int_core.sv
tb_clock_gen.sv
tb_int_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
TOP        ?= tb_int_core
RTL_TOP    ?= int_core
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_int_core.sv ====
// program uses word indices below DMEM_WORDS/2 and remote writes the rest; DMEM_WORDS <= 512
module tb_int_core;
  timeunit 1ns;
  timeprecision 1ns;
  import core_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int DMEM_WORDS     = 256;
  localparam int PROG_WORDS     = DMEM_WORDS / 2;
  localparam int NUM_INSTR      = 300;
  localparam int NUM_REMOTE_WR  = 40;
  localparam int NUM_REMOTE     = 2 * DMEM_WORDS + NUM_REMOTE_WR;
  localparam int TIMEOUT_CYCLES = 20 * (NUM_INSTR + NUM_REMOTE + 50);
  localparam logic [31:0] SEED  = 32'hd199_acd5;

  logic              clk_i;
  logic              reset_i;
  logic              instr_v_i;
  instr_u            instr_i;
  logic              instr_yumi_o;
  logic              remote_v_i;
  dmem_req_s         remote_req_i;
  logic              remote_yumi_o;
  logic [DATA_W-1:0] remote_data_o;
  rf_write_s         retire_o;

  // reference state and the writes still expected on retire_o
  logic [31:0] model_rf [32];
  logic [31:0] model_mem [DMEM_WORDS];
  rf_write_s   exp_q [$];
  logic [31:0] prog [NUM_INSTR];
  int          prog_gap [NUM_INSTR];
  logic [9:0]  rw_addr [NUM_REMOTE_WR];
  logic [31:0] rw_data [NUM_REMOTE_WR];
  int          rw_gap [NUM_REMOTE_WR];
  int          errors;
  int          checks;
  logic        load_pending;
  logic [4:0]  load_rd;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  int_core #(
    .DMEM_WORDS (DMEM_WORDS)
  ) UUT (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_v_i     (instr_v_i),
    .instr_i       (instr_i),
    .instr_yumi_o  (instr_yumi_o),
    .remote_v_i    (remote_v_i),
    .remote_req_i  (remote_req_i),
    .remote_yumi_o (remote_yumi_o),
    .remote_data_o (remote_data_o),
    .retire_o      (retire_o)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a3c_0f96;
  endfunction

  // mostly x0..x7 so that neighbours depend on each other
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(0, 7) == 0) begin
      return 5'($urandom_range(0, 31));
    end
    return 5'($urandom_range(0, 7));
  endfunction

  // base x0; the negative form aliases to the same index once truncated
  function automatic logic [11:0] mem_imm();
    logic [10:0] ofs;
    ofs = 11'($urandom_range(0, PROG_WORDS - 1) * 4);
    return {1'($urandom_range(0, 1)), ofs};
  endfunction

  function automatic logic [31:0] gen_instr();
    instr_u     w;
    int         kind;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    kind = $urandom_range(0, 99);
    rs1 = pick_reg();
    rs2 = pick_reg();
    rd = pick_reg();
    w = '0;
    // consumer right behind a load
    if (load_pending && kind < 50) begin
      if ($urandom_range(0, 1) == 1) begin
        rs1 = load_rd;
      end else begin
        rs2 = load_rd;
      end
      kind = 0;
    end
    load_pending = 1'b0;
    if (kind < 30) begin
      w.r_fmt.opcode = OP_REG;
      w.r_fmt.rd = rd;
      w.r_fmt.rs1 = rs1;
      w.r_fmt.rs2 = rs2;
      case ($urandom_range(0, 5))
        0: w.r_fmt.funct3 = F3_ADD;
        1: begin
          w.r_fmt.funct3 = F3_ADD;
          w.r_fmt.funct7 = 7'h20;
        end
        2: w.r_fmt.funct3 = F3_SLT;
        3: w.r_fmt.funct3 = F3_XOR;
        4: w.r_fmt.funct3 = F3_OR;
        default: w.r_fmt.funct3 = F3_AND;
      endcase
    end else if (kind < 55) begin
      w.i_fmt.opcode = OP_IMM;
      w.i_fmt.rd = rd;
      w.i_fmt.rs1 = rs1;
      w.i_fmt.imm12 = 12'($urandom);
      case ($urandom_range(0, 4))
        0: w.i_fmt.funct3 = F3_ADD;
        1: w.i_fmt.funct3 = F3_SLT;
        2: w.i_fmt.funct3 = F3_XOR;
        3: w.i_fmt.funct3 = F3_OR;
        default: w.i_fmt.funct3 = F3_AND;
      endcase
    end else if (kind < 70) begin
      w.i_fmt.opcode = OP_LOAD;
      w.i_fmt.funct3 = F3_LW_SW;
      w.i_fmt.rd = rd;
      w.i_fmt.imm12 = mem_imm();
      load_pending = 1'b1;
      load_rd = rd;
    end else if (kind < 85) begin
      w.s_fmt.opcode = OP_STORE;
      w.s_fmt.funct3 = F3_LW_SW;
      w.s_fmt.rs2 = rs2;
      {w.s_fmt.imm_hi, w.s_fmt.imm_lo} = mem_imm();
    end else begin
      // branch or lui, mul, lb, sb, slli
      w = $urandom;
      case ($urandom_range(0, 4))
        0: w.r_fmt.opcode = ($urandom_range(0, 1) == 1) ? 7'b1100011 : 7'b0110111;
        1: begin
          w.r_fmt.opcode = OP_REG;
          w.r_fmt.funct7 = 7'h01;
        end
        2: begin
          w.i_fmt.opcode = OP_LOAD;
          w.i_fmt.funct3 = 3'b000;
        end
        3: begin
          w.s_fmt.opcode = OP_STORE;
          w.s_fmt.funct3 = 3'b000;
        end
        default: begin
          w.i_fmt.opcode = OP_IMM;
          w.i_fmt.funct3 = 3'b001;
        end
      endcase
    end
    return w;
  endfunction

  // in-order RV32I reference for one accepted word
  task automatic apply_model(input logic [31:0] w);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] result;
    logic        writes;
    int          idx;
    rf_write_s   e;
    rd = w[11:7];
    f3 = w[14:12];
    f7 = w[31:25];
    a = model_rf[w[19:15]];
    b = model_rf[w[24:20]];
    imm_i = sext12(w[31:20]);
    writes = 1'b1;
    result = '0;
    if (w[6:0] == 7'b0110011) begin
      case ({f7, f3})
        10'b0000000_000: result = a + b;
        10'b0100000_000: result = a - b;
        10'b0000000_010: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        10'b0000000_100: result = a ^ b;
        10'b0000000_110: result = a | b;
        10'b0000000_111: result = a & b;
        default: writes = 1'b0;
      endcase
    end else if (w[6:0] == 7'b0010011) begin
      case (f3)
        3'b000: result = a + imm_i;
        3'b010: result = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
        3'b100: result = a ^ imm_i;
        3'b110: result = a | imm_i;
        3'b111: result = a & imm_i;
        default: writes = 1'b0;
      endcase
    end else if (w[6:0] == 7'b0000011 && f3 == 3'b010) begin
      idx = int'(result_index(a + imm_i));
      result = model_mem[idx];
    end else begin
      writes = 1'b0;
      if (w[6:0] == 7'b0100011 && f3 == 3'b010) begin
        idx = int'(result_index(a + sext12({w[31:25], w[11:7]})));
        model_mem[idx] = b;
      end
    end
    if (writes && rd != 5'd0) begin
      model_rf[rd] = result;
      e.valid = 1'b1;
      e.rd = rd;
      e.data = result;
      exp_q.push_back(e);
    end
  endtask

  // byte address bits 11:2, then only the implemented words
  function automatic logic [9:0] result_index(input logic [31:0] addr);
    return 10'(int'(addr[11:2]) % DMEM_WORDS);
  endfunction

  task automatic remote_access(input logic w, input logic [9:0] addr, input logic [31:0] data,
                               output logic [31:0] rdata);
    @(negedge clk_i);
    remote_v_i = 1'b1;
    remote_req_i.w = w;
    remote_req_i.addr = addr;
    remote_req_i.data = data;
    do @(posedge clk_i); while (!remote_yumi_o);
    @(negedge clk_i);
    remote_v_i = 1'b0;
    rdata = remote_data_o;
  endtask

  task automatic run_program();
    for (int n = 0; n < NUM_INSTR; n++) begin
      repeat (prog_gap[n]) begin
        @(negedge clk_i);
        instr_v_i = 1'b0;
      end
      @(negedge clk_i);
      instr_v_i = 1'b1;
      instr_i = prog[n];
      do @(posedge clk_i); while (!instr_yumi_o);
      apply_model(prog[n]);
    end
    @(negedge clk_i);
    instr_v_i = 1'b0;
  endtask

  task automatic issue_remote_writes();
    logic [31:0] rdata;
    for (int j = 0; j < NUM_REMOTE_WR; j++) begin
      repeat (rw_gap[j]) @(negedge clk_i);
      remote_access(1'b1, rw_addr[j], rw_data[j], rdata);
      model_mem[int'(rw_addr[j])] = rw_data[j];
    end
  endtask

  always @(posedge clk_i) begin
    rf_write_s e;
    if (!reset_i && retire_o.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: %0t retire_o wrote x%0d but the program has no write left",
                 $time, retire_o.rd);
      end else begin
        e = exp_q.pop_front();
        check_value("retire_o.rd", 32'(retire_o.rd), 32'(e.rd));
        check_value("retire_o.data", retire_o.data, e.data);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, %0d writes never retired, %0d errors",
             TIMEOUT_CYCLES, exp_q.size(), errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    logic [9:0]  addr;
    void'($urandom(SEED));
    instr_v_i = 1'b0;
    instr_i = '0;
    remote_v_i = 1'b0;
    remote_req_i = '0;
    errors = 0;
    checks = 0;
    load_pending = 1'b0;
    load_rd = '0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    for (int n = 0; n < NUM_INSTR; n++) begin
      prog[n] = gen_instr();
      prog_gap[n] = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
    end
    for (int j = 0; j < NUM_REMOTE_WR; j++) begin
      rw_addr[j] = 10'($urandom_range(PROG_WORDS, DMEM_WORDS - 1));
      rw_data[j] = $urandom;
      rw_gap[j] = int'($urandom_range(0, 8));
    end
    // first edge loads the reset values
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk_i);
      if (c > 0) begin
        check_value("instr_yumi_o", 32'(instr_yumi_o), 32'd0);
        check_value("remote_yumi_o", 32'(remote_yumi_o), 32'd0);
        check_value("retire_o.valid", 32'(retire_o.valid), 32'd0);
      end
    end
    wait (!reset_i);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      remote_access(1'b1, 10'(i), fill_word(i), rdata);
      model_mem[i] = fill_word(i);
    end
    fork
      run_program();
      issue_remote_writes();
    join
    while (exp_q.size() != 0) @(posedge clk_i);
    // last stores still crossing EXE and MEM
    repeat (8) @(posedge clk_i);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      addr = 10'(i + DMEM_WORDS * int'($urandom_range(0, 3)));
      remote_access(1'b0, addr, $urandom, rdata);
      check_value($sformatf("remote_data_o[%0d]", i), rdata,
                  model_mem[int'(addr) % DMEM_WORDS]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
// clock runs from time zero; reset is released on a falling edge after RESET_CYCLES rising edges
module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    // release with the other inputs
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

// ==== int_core.sv ====
// no fetch or branches; instructions arrive in order on a valid/yumi stream
module int_core #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         instr_v_i,
  input  core_pkg::instr_u             instr_i,
  output logic                         instr_yumi_o,
  input  logic                         remote_v_i,
  input  core_pkg::dmem_req_s          remote_req_i,
  output logic                         remote_yumi_o,
  output logic [core_pkg::DATA_W-1:0]  remote_data_o,
  output core_pkg::rf_write_s          retire_o
);
  import core_pkg::*;

  exe_s              exe_next, exe_r;
  mem_s              mem_next;
  rf_write_s         wb;
  logic [DATA_W-1:0] mem_result;
  logic              dmem_v;
  dmem_req_s         dmem_req;

  decode_stage u_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .instr_v_i    (instr_v_i),
    .instr_i      (instr_i),
    .exe_i        (exe_r),
    .mem_next_i   (mem_next),
    .wb_i         (wb),
    .instr_yumi_o (instr_yumi_o),
    .exe_next_o   (exe_next)
  );

  execute_stage u_execute (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .exe_next_i   (exe_next),
    .mem_result_i (mem_result),
    .wb_i         (wb),
    .exe_o        (exe_r),
    .mem_next_o   (mem_next),
    .dmem_v_o     (dmem_v),
    .dmem_req_o   (dmem_req)
  );

  memory_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_memory (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mem_next_i    (mem_next),
    .dmem_v_i      (dmem_v),
    .dmem_req_i    (dmem_req),
    .remote_v_i    (remote_v_i),
    .remote_req_i  (remote_req_i),
    .mem_result_o  (mem_result),
    .wb_o          (wb),
    .remote_yumi_o (remote_yumi_o),
    .remote_data_o (remote_data_o)
  );

  // the WB register is the regfile write of this cycle
  assign retire_o = wb;

endmodule

// ==== memory_stage.sv ====
// DMEM_WORDS must be a power of two up to 1024; memory contents survive reset
module memory_stage #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  core_pkg::mem_s               mem_next_i,
  input  logic                         dmem_v_i,
  input  core_pkg::dmem_req_s          dmem_req_i,
  input  logic                         remote_v_i,
  input  core_pkg::dmem_req_s          remote_req_i,
  output logic [core_pkg::DATA_W-1:0]  mem_result_o,
  output core_pkg::rf_write_s          wb_o,
  output logic                         remote_yumi_o,
  output logic [core_pkg::DATA_W-1:0]  remote_data_o
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  mem_s              mem_r;
  rf_write_s         wb_r, wb_n;
  dmem_req_s         req;
  logic              req_v;
  logic [IDX_W-1:0]  dmem_idx;
  logic [DATA_W-1:0] rd_data_r;
  logic [DATA_W-1:0] dmem [DMEM_WORDS];

  // core access first, remote only in idle cycles
  assign remote_yumi_o = remote_v_i && !dmem_v_i;
  assign req_v = dmem_v_i || remote_v_i;
  assign req = dmem_v_i ? dmem_req_i : remote_req_i;
  assign dmem_idx = req.addr[IDX_W-1:0];

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (req_v) begin
      if (req.w) begin
        dmem[dmem_idx] <= req.data;
      end else begin
        rd_data_r <= dmem[dmem_idx];
      end
    end
  end

  assign remote_data_o = rd_data_r;

  // x0 writes never reach WB
  always_comb begin
    wb_n.valid = mem_r.valid && mem_r.writes_rd && mem_r.rd != '0;
    wb_n.rd = mem_r.rd;
    wb_n.data = mem_r.is_load ? rd_data_r : mem_r.exe_result;
  end

  always_ff @(posedge clk_i) begin
    mem_r <= mem_next_i;
    wb_r <= wb_n;
    if (reset_i) begin
      mem_r.valid <= 1'b0;
      wb_r.valid <= 1'b0;
    end
  end

  assign mem_result_o = mem_r.exe_result;
  assign wb_o = wb_r;

  // a load in MEM had the array read for it on the edge it left EXE
  a_load_read: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_r.valid && mem_r.is_load |-> $past(dmem_v_i && !dmem_req_i.w));

endmodule

// ==== execute_stage.sv ====
// single-cycle ALU; word index from address bits 11:2, no misalignment check
module execute_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  core_pkg::exe_s               exe_next_i,
  input  logic [core_pkg::DATA_W-1:0]  mem_result_i,
  input  core_pkg::rf_write_s          wb_i,
  output core_pkg::exe_s               exe_o,
  output core_pkg::mem_s               mem_next_o,
  output logic                         dmem_v_o,
  output core_pkg::dmem_req_s          dmem_req_o
);
  import core_pkg::*;

  exe_s              exe_r;
  logic [DATA_W-1:0] op_a, op_b;
  logic [DATA_W-1:0] alu_b;
  logic [DATA_W-1:0] alu_result;

  always_ff @(posedge clk_i) begin
    exe_r <= exe_next_i;
    if (reset_i) begin
      exe_r.valid <= 1'b0;
    end
  end

  assign exe_o = exe_r;

  // MEM is younger than WB, so it wins
  assign op_a = exe_r.rs1_in_mem ? mem_result_i
              : exe_r.rs1_in_wb  ? wb_i.data
              : exe_r.rs1_val;
  assign op_b = exe_r.rs2_in_mem ? mem_result_i
              : exe_r.rs2_in_wb  ? wb_i.data
              : exe_r.rs2_val;

  assign alu_b = exe_r.decode.use_imm ? exe_r.imm : op_b;

  always_comb begin
    case (exe_r.decode.alu_op)
      ALU_ADD: alu_result = op_a + alu_b;
      ALU_SUB: alu_result = op_a - alu_b;
      ALU_AND: alu_result = op_a & alu_b;
      ALU_OR:  alu_result = op_a | alu_b;
      ALU_XOR: alu_result = op_a ^ alu_b;
      ALU_SLT: alu_result = {{(DATA_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_result = '0;
    endcase
  end

  // lw/sw decode as add, so the ALU forms the byte address
  assign dmem_v_o = exe_r.valid && (exe_r.decode.is_load || exe_r.decode.is_store);
  assign dmem_req_o.w = exe_r.decode.is_store;
  assign dmem_req_o.addr = alu_result[DMEM_ADDR_W+1:2];
  assign dmem_req_o.data = op_b;

  always_comb begin
    mem_next_o.valid = exe_r.valid;
    mem_next_o.writes_rd = exe_r.valid && exe_r.decode.writes_rd;
    mem_next_o.is_load = exe_r.decode.is_load;
    mem_next_o.rd = exe_r.rd;
    mem_next_o.exe_result = alu_result;
  end

  // decode marks exactly one of load/store, always with an immediate
  a_dmem_src: assert property (@(posedge clk_i) disable iff (reset_i)
    dmem_v_o |-> exe_r.decode.use_imm
      && (exe_r.decode.is_load != exe_r.decode.is_store)
      && (exe_r.decode.writes_rd == exe_r.decode.is_load));

endmodule

// ==== decode_stage.sv ====
// unsupported opcodes pass on as no-ops; a load in EXE feeding ID costs one bubble
module decode_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 instr_v_i,
  input  core_pkg::instr_u     instr_i,
  input  core_pkg::exe_s       exe_i,
  input  core_pkg::mem_s       mem_next_i,
  input  core_pkg::rf_write_s  wb_i,
  output logic                 instr_yumi_o,
  output core_pkg::exe_s       exe_next_o
);
  import core_pkg::*;

  id_s                   id_r, id_n;
  instr_u                ir;
  decode_s               dec;
  logic [DATA_W-1:0]     imm_i, imm_s;
  logic [DATA_W-1:0]     rf_rs1, rf_rs2;
  logic                  stall;
  logic                  mem_wr_r;
  logic [REG_ADDR_W-1:0] mem_rd_r;

  assign ir = id_r.instr;

  // load in EXE whose result ID needs now
  assign stall = id_r.valid && exe_i.valid && exe_i.decode.is_load && exe_i.rd != '0
    && ((dec.reads_rs1 && ir.r_fmt.rs1 == exe_i.rd)
      || (dec.reads_rs2 && ir.r_fmt.rs2 == exe_i.rd));

  assign instr_yumi_o = instr_v_i && !stall;

  always_comb begin
    if (stall) begin
      id_n = id_r;
    end else begin
      id_n.valid = instr_v_i;
      id_n.instr = instr_i;
    end
  end

  // shadow of the MEM destination, which sits in WB while this instruction executes
  always_ff @(posedge clk_i) begin
    id_r <= id_n;
    mem_rd_r <= mem_next_i.rd;
    if (reset_i) begin
      id_r.valid <= 1'b0;
      mem_wr_r <= 1'b0;
    end else begin
      mem_wr_r <= mem_next_i.valid && mem_next_i.writes_rd && mem_next_i.rd != '0;
    end
  end

  always_comb begin
    // no-op by default
    dec = '0;
    case (ir.r_fmt.opcode)
      OP_REG: begin
        dec.reads_rs1 = 1'b1;
        dec.reads_rs2 = 1'b1;
        dec.writes_rd = 1'b1;
        case ({ir.r_fmt.funct7, ir.r_fmt.funct3})
          {7'h00, F3_ADD}: dec.alu_op = ALU_ADD;
          {7'h20, F3_ADD}: dec.alu_op = ALU_SUB;
          {7'h00, F3_SLT}: dec.alu_op = ALU_SLT;
          {7'h00, F3_XOR}: dec.alu_op = ALU_XOR;
          {7'h00, F3_OR}:  dec.alu_op = ALU_OR;
          {7'h00, F3_AND}: dec.alu_op = ALU_AND;
          default:         dec = '0;
        endcase
      end
      OP_IMM: begin
        dec.reads_rs1 = 1'b1;
        dec.writes_rd = 1'b1;
        dec.use_imm = 1'b1;
        case (ir.i_fmt.funct3)
          F3_ADD:  dec.alu_op = ALU_ADD;
          F3_SLT:  dec.alu_op = ALU_SLT;
          F3_XOR:  dec.alu_op = ALU_XOR;
          F3_OR:   dec.alu_op = ALU_OR;
          F3_AND:  dec.alu_op = ALU_AND;
          default: dec = '0;
        endcase
      end
      OP_LOAD: begin
        if (ir.i_fmt.funct3 == F3_LW_SW) begin
          dec.reads_rs1 = 1'b1;
          dec.writes_rd = 1'b1;
          dec.is_load = 1'b1;
          dec.use_imm = 1'b1;
        end
      end
      OP_STORE: begin
        if (ir.s_fmt.funct3 == F3_LW_SW) begin
          dec.reads_rs1 = 1'b1;
          dec.reads_rs2 = 1'b1;
          dec.is_store = 1'b1;
          dec.use_imm = 1'b1;
        end
      end
      default: dec = '0;
    endcase
  end

  assign imm_i = {{(DATA_W-12){ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
  assign imm_s = {{(DATA_W-12){ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};

  regfile u_regfile (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .write_i    (wb_i),
    .rs1_addr_i (ir.r_fmt.rs1),
    .rs2_addr_i (ir.r_fmt.rs2),
    .rs1_data_o (rf_rs1),
    .rs2_data_o (rf_rs2)
  );

  always_comb begin
    exe_next_o = '0;
    if (id_r.valid && !stall) begin
      exe_next_o.valid = 1'b1;
      exe_next_o.decode = dec;
      exe_next_o.rd = ir.r_fmt.rd;
      exe_next_o.imm = dec.is_store ? imm_s : imm_i;
      // WB writes the regfile on this same edge
      exe_next_o.rs1_val = (wb_i.valid && wb_i.rd == ir.r_fmt.rs1) ? wb_i.data : rf_rs1;
      exe_next_o.rs2_val = (wb_i.valid && wb_i.rd == ir.r_fmt.rs2) ? wb_i.data : rf_rs2;
      // load results never forward from MEM, the stall covers that case
      exe_next_o.rs1_in_mem = dec.reads_rs1 && mem_next_i.valid && mem_next_i.writes_rd
        && !mem_next_i.is_load && mem_next_i.rd != '0 && mem_next_i.rd == ir.r_fmt.rs1;
      exe_next_o.rs2_in_mem = dec.reads_rs2 && mem_next_i.valid && mem_next_i.writes_rd
        && !mem_next_i.is_load && mem_next_i.rd != '0 && mem_next_i.rd == ir.r_fmt.rs2;
      exe_next_o.rs1_in_wb = dec.reads_rs1 && mem_wr_r && mem_rd_r == ir.r_fmt.rs1;
      exe_next_o.rs2_in_wb = dec.reads_rs2 && mem_wr_r && mem_rd_r == ir.r_fmt.rs2;
    end
  end

  // the bubble empties EXE, so a load-use stall never lasts two cycles
  a_one_bubble: assert property (@(posedge clk_i) disable iff (reset_i)
    stall |=> !stall);

endmodule

// ==== regfile.sv ====
// two async read ports, one sync write port; x0 reads as zero and ignores writes
module regfile (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  core_pkg::rf_write_s                 write_i,
  input  logic [core_pkg::REG_ADDR_W-1:0]     rs1_addr_i,
  input  logic [core_pkg::REG_ADDR_W-1:0]     rs2_addr_i,
  output logic [core_pkg::DATA_W-1:0]         rs1_data_o,
  output logic [core_pkg::DATA_W-1:0]         rs2_data_o
);
  import core_pkg::*;

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [DATA_W-1:0] rf [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (write_i.valid && write_i.rd != '0) begin
      rf[write_i.rd] <= write_i.data;
    end
  end

  // x0 hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

endmodule

// ==== core_pkg.sv ====
// RV32I word subset only; data memory index capped at 10 bits, upper address bits ignored
package core_pkg;

  localparam int DATA_W      = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int DMEM_ADDR_W = 10;

  // rv32i major opcodes
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  localparam logic [2:0] F3_ADD   = 3'b000;
  localparam logic [2:0] F3_SLT   = 3'b010;
  localparam logic [2:0] F3_XOR   = 3'b100;
  localparam logic [2:0] F3_OR    = 3'b110;
  localparam logic [2:0] F3_AND   = 3'b111;
  localparam logic [2:0] F3_LW_SW = 3'b010;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_s;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_s;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_s;

  // one instruction word, three ways of reading it
  typedef union packed {
    r_fmt_s r_fmt;
    i_fmt_s i_fmt;
    s_fmt_s s_fmt;
  } instr_u;

  // add must stay zero, a cleared decode is a plain add
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic    reads_rs1;
    logic    reads_rs2;
    logic    writes_rd;
    logic    is_load;
    logic    is_store;
    logic    use_imm;
    alu_op_e alu_op;
  } decode_s;

  typedef struct packed {
    logic   valid;
    instr_u instr;
  } id_s;

  typedef struct packed {
    logic                  valid;
    decode_s               decode;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     imm;
    logic [DATA_W-1:0]     rs1_val;
    logic [DATA_W-1:0]     rs2_val;
    logic                  rs1_in_mem;
    logic                  rs1_in_wb;
    logic                  rs2_in_mem;
    logic                  rs2_in_wb;
  } exe_s;

  typedef struct packed {
    logic                  valid;
    logic                  writes_rd;
    logic                  is_load;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     exe_result;
  } mem_s;

  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     data;
  } rf_write_s;

  typedef struct packed {
    logic                   w;
    logic [DMEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      data;
  } dmem_req_s;

endpackage
